// File: logic/readout_pkg.sv
// Shared definitions for the readout core
// Bus address map and register offsets
// Data word fields and source identifiers
// FIFO sizing and arbiter index widths
// Pulse generator state encoding

`default_nettype none

package readout_pkg;

    // Sizes
    localparam int N_SOURCES  = 2;
    localparam int FIFO_DEPTH = 4;                     // Power of two, pointers wrap naturally
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int SRC_IDX_W  = $clog2(N_SOURCES);

    // Vector types
    typedef logic [15:0]           addr_t;
    typedef logic [7:0]            bus_data_t;
    typedef logic [31:0]           word_t;
    typedef logic [15:0]           count_t;
    typedef logic [3:0]            data_id_t;
    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_PTR_W:0]   fifo_lvl_t;         // One extra bit to tell full from empty
    typedef logic [SRC_IDX_W-1:0]  src_idx_t;

    typedef enum logic [1:0] {
        PULSE_IDLE,
        PULSE_DELAY,
        PULSE_HIGH
    } pulse_state_t;

    // Block bases on the register bus
    localparam addr_t CFG_BASEADDR  = 16'h8800;
    localparam addr_t GATE_BASEADDR = 16'h8A00;
    localparam addr_t INJ_BASEADDR  = 16'h8A80;

    // Pulse generator offsets
    localparam addr_t REG_DELAY = 16'd0;
    localparam addr_t REG_WIDTH = 16'd1;
    localparam addr_t REG_START = 16'd2;

    // Configuration block offsets
    localparam addr_t REG_ENABLE  = 16'd0;
    localparam addr_t REG_VERSION = 16'd1;
    localparam addr_t REG_LOST    = 16'd2;
    localparam addr_t REG_CLEAR   = 16'd3;

    // Identifiers in the top nibble of an output word
    localparam data_id_t TRG_DATA_ID = 4'd4;
    localparam data_id_t INJ_DATA_ID = 4'd5;

    localparam bus_data_t VERSION = 8'd4;

endpackage

`default_nettype wire

// File: logic/pulse_gen.sv
// Delayed pulse generator
// Delay and width registers on the register bus
// Start by a bus write or by the rising edge of an external input
// Output registered, high for width cycles after delay+1 cycles

`timescale 1ns/100ps
`default_nettype none

module pulse_gen
    import readout_pkg::*;
#(
    parameter addr_t BASEADDR = GATE_BASEADDR
) (
    input  wire            CLK_40,
    input  wire            i_arst_n,
    input  wire addr_t     i_bus_addr,
    input  wire bus_data_t i_bus_wdata,
    input  wire            i_bus_wr,
    input  wire            i_ext_start,
    output logic           o_pulse
);

    pulse_state_t state;
    bus_data_t    delay_q;
    bus_data_t    width_q;
    bus_data_t    cnt;          // Shared by the delay and the width phase
    logic         ext_q;        // Previous i_ext_start for edge detection
    logic         wr_delay;
    logic         wr_width;
    logic         wr_start;
    logic         start;

    assign wr_delay = i_bus_wr && (i_bus_addr == BASEADDR + REG_DELAY);
    assign wr_width = i_bus_wr && (i_bus_addr == BASEADDR + REG_WIDTH);
    assign wr_start = i_bus_wr && (i_bus_addr == BASEADDR + REG_START);

    // Zero width means nothing to do
    assign start = (wr_start || (i_ext_start && !ext_q)) && (width_q != '0);

    always_ff @(posedge CLK_40 or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            delay_q <= '0;
            width_q <= '0;
            ext_q   <= 1'b0;
        end
        else
        begin
            ext_q <= i_ext_start;
            if (wr_delay)
                delay_q <= i_bus_wdata;
            if (wr_width)
                width_q <= i_bus_wdata;
        end
    end

    always_ff @(posedge CLK_40 or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state   <= PULSE_IDLE;
            cnt     <= '0;
            o_pulse <= 1'b0;
        end
        else
        begin
            case (state)
                PULSE_IDLE:
                begin
                    if (start)              // Starts only accepted here
                    begin
                        state <= PULSE_DELAY;
                        cnt   <= delay_q;
                    end
                end
                PULSE_DELAY:
                begin
                    if (cnt != '0)
                        cnt <= cnt - 8'd1;
                    else if (width_q == '0) // Width cleared while waiting
                        state <= PULSE_IDLE;
                    else
                    begin
                        state   <= PULSE_HIGH;
                        o_pulse <= 1'b1;
                        cnt     <= width_q - 8'd1;
                    end
                end
                PULSE_HIGH:
                begin
                    if (cnt != '0)
                        cnt <= cnt - 8'd1;
                    else
                    begin
                        state   <= PULSE_IDLE;
                        o_pulse <= 1'b0;
                    end
                end
                default:
                begin
                    state   <= PULSE_IDLE;
                    o_pulse <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/event_fifo.sv
// Event source for the readout stream
// Two-stage synchronizer and rising-edge detector on the event input
// Event counter with clear, word tagging with the source identifier
// Small FIFO with full flag and lost-event pulse

`timescale 1ns/100ps
`default_nettype none

module event_fifo
    import readout_pkg::*;
#(
    parameter data_id_t DATA_ID = TRG_DATA_ID
) (
    input  wire   CLK_40,
    input  wire   i_arst_n,
    input  wire   i_event,
    input  wire   i_enable,
    input  wire   i_count_clear,
    input  wire   i_pop,
    output logic  o_empty,
    output logic  o_full,
    output word_t o_word,
    output logic  o_lost
);

    logic [2:0] ev_sync;        // Two sync stages plus one for edge history
    logic       ev_rise;
    logic       ev_take;
    logic       push;
    logic       pop_ok;
    count_t     ev_cnt;
    fifo_ptr_t  wr_ptr;
    fifo_ptr_t  rd_ptr;
    fifo_lvl_t  level;
    word_t      mem [FIFO_DEPTH];

    assign ev_rise = ev_sync[1] & ~ev_sync[2];
    assign ev_take = ev_rise & i_enable;
    assign push    = ev_take & ~o_full;
    assign pop_ok  = i_pop & ~o_empty;

    assign o_empty = (level == '0);
    assign o_full  = (level == fifo_lvl_t'(FIFO_DEPTH));
    assign o_word  = mem[rd_ptr];

    always_ff @(posedge CLK_40 or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            ev_sync <= '0;
            ev_cnt  <= '0;
            o_lost  <= 1'b0;
        end
        else
        begin
            ev_sync <= {ev_sync[1:0], i_event};
            o_lost  <= ev_take & o_full;            // Dropped word still gets a number
            if (i_count_clear)
                ev_cnt <= '0;
            else if (ev_take)
                ev_cnt <= ev_cnt + 16'd1;
        end
    end

    always_ff @(posedge CLK_40 or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop_ok})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // Word is id, zero padding, event number
    always_ff @(posedge CLK_40)
    begin
        if (push)
            mem[wr_ptr] <= {DATA_ID, 12'h000, ev_cnt};
    end

endmodule

`default_nettype wire

// File: logic/rr_arbiter.sv
// Round-robin merge of the source FIFOs
// Grants the next non-empty source after the last granted one
// Registered output word with valid/ready handshake

`timescale 1ns/100ps
`default_nettype none

module rr_arbiter
    import readout_pkg::*;
(
    input  wire                         CLK_40,
    input  wire                         i_arst_n,
    input  wire [N_SOURCES-1:0]         i_empty,
    input  wire word_t [N_SOURCES-1:0]  i_word,
    input  wire                         i_data_ready,
    output logic [N_SOURCES-1:0]        o_pop,
    output logic                        o_data_valid,
    output word_t                       o_data
);

    src_idx_t last_idx;
    src_idx_t grant_idx;
    logic     grant_found;
    logic     load;

    // Output register free or being taken this cycle
    assign load = ~o_data_valid | i_data_ready;

    always_comb
    begin
        int cand;
        grant_found = 1'b0;
        grant_idx   = last_idx;
        for (int k = 1; k <= N_SOURCES; k++)
        begin
            cand = (int'(last_idx) + k) % N_SOURCES;
            if (!grant_found && !i_empty[cand])
            begin
                grant_found = 1'b1;
                grant_idx   = src_idx_t'(cand);
            end
        end
    end

    always_comb
    begin
        o_pop = '0;
        if (load && grant_found)
            o_pop[grant_idx] = 1'b1;
    end

    always_ff @(posedge CLK_40 or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_data_valid <= 1'b0;
            last_idx     <= src_idx_t'(N_SOURCES - 1);  // Source 0 goes first
        end
        else if (load)
        begin
            o_data_valid <= grant_found;
            if (grant_found)
                last_idx <= grant_idx;
        end
    end

    always_ff @(posedge CLK_40)
    begin
        if (load && grant_found)
            o_data <= i_word[grant_idx];
    end

endmodule

`default_nettype wire

// File: logic/config_regs.sv
// Configuration registers of the readout core
// Source enables, read-only version byte
// Sticky lost-event flags, event counter clear pulse
// Registered bus read port, busy flag from the FIFO full lines

`timescale 1ns/100ps
`default_nettype none

module config_regs
    import readout_pkg::*;
#(
    parameter addr_t BASEADDR = CFG_BASEADDR
) (
    input  wire                  CLK_40,
    input  wire                  i_arst_n,
    input  wire addr_t           i_bus_addr,
    input  wire bus_data_t       i_bus_wdata,
    input  wire                  i_bus_wr,
    input  wire                  i_bus_rd,
    input  wire [N_SOURCES-1:0]  i_lost,
    input  wire [N_SOURCES-1:0]  i_full,
    output bus_data_t            o_bus_rdata,
    output logic [N_SOURCES-1:0] o_enable,
    output logic                 o_count_clear,
    output logic                 o_busy
);

    logic [N_SOURCES-1:0] lost_q;
    logic                 wr_enable;
    logic                 wr_lost;
    logic                 wr_clear;
    bus_data_t            rd_mux;

    assign wr_enable = i_bus_wr && (i_bus_addr == BASEADDR + REG_ENABLE);
    assign wr_lost   = i_bus_wr && (i_bus_addr == BASEADDR + REG_LOST);
    assign wr_clear  = i_bus_wr && (i_bus_addr == BASEADDR + REG_CLEAR);

    assign o_busy = |i_full;

    always_comb
    begin
        case (i_bus_addr)
            BASEADDR + REG_ENABLE:  rd_mux = bus_data_t'(o_enable);
            BASEADDR + REG_VERSION: rd_mux = VERSION;
            BASEADDR + REG_LOST:    rd_mux = bus_data_t'(lost_q);
            default:                rd_mux = '0;   // Unmapped reads give zero
        endcase
    end

    always_ff @(posedge CLK_40 or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_enable      <= '0;
            lost_q        <= '0;
            o_count_clear <= 1'b0;
            o_bus_rdata   <= '0;
        end
        else
        begin
            if (wr_enable)
                o_enable <= i_bus_wdata[N_SOURCES-1:0];

            // A new loss in the clearing cycle stays flagged
            lost_q <= (wr_lost ? '0 : lost_q) | i_lost;

            o_count_clear <= wr_clear;          // One cycle wide

            if (i_bus_rd)
                o_bus_rdata <= rd_mux;          // Holds between reads
        end
    end

endmodule

`default_nettype wire

// File: logic/readout_top.sv
// Top level of the readout core
// Gate and injection pulse generators, injection chained to the gate
// Trigger and gate event sources
// Round-robin output arbiter and configuration registers

`timescale 1ns/100ps
`default_nettype none

module readout_top
    import readout_pkg::*;
(
    input  wire            CLK_40,
    input  wire            i_arst_n,
    input  wire addr_t     i_bus_addr,
    input  wire bus_data_t i_bus_wdata,
    input  wire            i_bus_wr,
    input  wire            i_bus_rd,
    input  wire            i_trigger,
    input  wire            i_data_ready,
    output bus_data_t      o_bus_rdata,
    output logic           o_data_valid,
    output word_t          o_data,
    output logic           o_busy,
    output logic           o_gate,
    output logic           o_inj_strb
);

    // Source 0 is the trigger, source 1 the injection
    wire [N_SOURCES-1:0]        src_enable;
    wire [N_SOURCES-1:0]        src_empty;
    wire [N_SOURCES-1:0]        src_full;
    wire [N_SOURCES-1:0]        src_lost;
    wire [N_SOURCES-1:0]        src_pop;
    wire word_t [N_SOURCES-1:0] src_word;
    wire                        count_clear;

    pulse_gen #(.BASEADDR(GATE_BASEADDR)) u_gate_pulse (
        .CLK_40      (CLK_40),
        .i_arst_n    (i_arst_n),
        .i_bus_addr  (i_bus_addr),
        .i_bus_wdata (i_bus_wdata),
        .i_bus_wr    (i_bus_wr),
        .i_ext_start (1'b0),            // Bus start only
        .o_pulse     (o_gate)
    );

    pulse_gen #(.BASEADDR(INJ_BASEADDR)) u_inj_pulse (
        .CLK_40      (CLK_40),
        .i_arst_n    (i_arst_n),
        .i_bus_addr  (i_bus_addr),
        .i_bus_wdata (i_bus_wdata),
        .i_bus_wr    (i_bus_wr),
        .i_ext_start (o_gate),          // Gate rise starts the injection delay
        .o_pulse     (o_inj_strb)
    );

    event_fifo #(.DATA_ID(TRG_DATA_ID)) u_trg_src (
        .CLK_40        (CLK_40),
        .i_arst_n      (i_arst_n),
        .i_event       (i_trigger),
        .i_enable      (src_enable[0]),
        .i_count_clear (count_clear),
        .i_pop         (src_pop[0]),
        .o_empty       (src_empty[0]),
        .o_full        (src_full[0]),
        .o_word        (src_word[0]),
        .o_lost        (src_lost[0])
    );

    event_fifo #(.DATA_ID(INJ_DATA_ID)) u_inj_src (
        .CLK_40        (CLK_40),
        .i_arst_n      (i_arst_n),
        .i_event       (o_gate),
        .i_enable      (src_enable[1]),
        .i_count_clear (count_clear),
        .i_pop         (src_pop[1]),
        .o_empty       (src_empty[1]),
        .o_full        (src_full[1]),
        .o_word        (src_word[1]),
        .o_lost        (src_lost[1])
    );

    rr_arbiter u_rr_arbiter (
        .CLK_40       (CLK_40),
        .i_arst_n     (i_arst_n),
        .i_empty      (src_empty),
        .i_word       (src_word),
        .i_data_ready (i_data_ready),
        .o_pop        (src_pop),
        .o_data_valid (o_data_valid),
        .o_data       (o_data)
    );

    config_regs #(.BASEADDR(CFG_BASEADDR)) u_config_regs (
        .CLK_40        (CLK_40),
        .i_arst_n      (i_arst_n),
        .i_bus_addr    (i_bus_addr),
        .i_bus_wdata   (i_bus_wdata),
        .i_bus_wr      (i_bus_wr),
        .i_bus_rd      (i_bus_rd),
        .i_lost        (src_lost),
        .i_full        (src_full),
        .o_bus_rdata   (o_bus_rdata),
        .o_enable      (src_enable),
        .o_count_clear (count_clear),
        .o_busy        (o_busy)
    );

endmodule

`default_nettype wire

// File: dv/readout_properties.sv
// Concurrent assertions on the readout core ports
// Output hold under back-pressure, cause of the injection strobe
// Busy flag low out of reset

`timescale 1ns/100ps
`default_nettype none

module readout_properties
    import readout_pkg::*;
(
    input wire        CLK_40,
    input wire        i_arst_n,
    input wire addr_t i_bus_addr,
    input wire        i_bus_wr,
    input wire        i_data_ready,
    input wire        o_data_valid,
    input wire word_t o_data,
    input wire        o_busy,
    input wire        o_gate,
    input wire        o_inj_strb
);

    int   assert_fail_cnt = 0;
    logic gate_q;
    logic inj_q;
    logic inj_armed;        // Gate rise or injection start seen since the last strobe
    logic inj_start_wr;

    assign inj_start_wr = i_bus_wr && (i_bus_addr == INJ_BASEADDR + REG_START);

    always_ff @(posedge CLK_40 or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            gate_q    <= 1'b0;
            inj_q     <= 1'b0;
            inj_armed <= 1'b0;
        end
        else
        begin
            gate_q <= o_gate;
            inj_q  <= o_inj_strb;
            if ((o_gate && !gate_q) || inj_start_wr)
                inj_armed <= 1'b1;
            else if (o_inj_strb && !inj_q)
                inj_armed <= 1'b0;
        end
    end

    a_valid_hold: assert property (@(posedge CLK_40) disable iff (!i_arst_n)
        (o_data_valid && !i_data_ready) |=> (o_data_valid && $stable(o_data)))
    else
    begin
        $error("o_data_valid or o_data changed while i_data_ready was low");
        assert_fail_cnt++;
    end

    a_inj_cause: assert property (@(posedge CLK_40) disable iff (!i_arst_n)
        $rose(o_inj_strb) |-> inj_armed)
    else
    begin
        $error("o_inj_strb rose without a gate rise or injection start");
        assert_fail_cnt++;
    end

    a_busy_reset: assert property (@(posedge CLK_40)
        (!i_arst_n || $rose(i_arst_n)) |-> !o_busy)
    else
    begin
        $error("o_busy high out of reset");
        assert_fail_cnt++;
    end

endmodule

bind readout_top readout_properties u_readout_props (.*);

`default_nettype wire

// File: dv/readout_tb.sv
// Testbench for the readout core
// Clock, reset, stimulus table and the loop that applies it
// Output stream reader, compare tasks, cycle watchdog

`timescale 1ns/100ps
`default_nettype none

module readout_tb
    import readout_pkg::*;
();

    typedef enum {OP_WRITE, OP_READ, OP_TRIG, OP_WORD, OP_WAIT, OP_READY, OP_PULSE, OP_FLAGS,
                  OP_IDLE} op_t;

    logic        CLK_40;
    logic        i_arst_n;
    addr_t       i_bus_addr;
    bus_data_t   i_bus_wdata;
    logic        i_bus_wr;
    logic        i_bus_rd;
    logic        i_trigger;
    logic        i_data_ready;
    bus_data_t   o_bus_rdata;
    logic        o_data_valid;
    word_t       o_data;
    logic        o_busy;
    logic        o_gate;
    logic        o_inj_strb;

    op_t         tbl_op[$];
    addr_t       tbl_addr[$];
    bus_data_t   tbl_data[$];     // Write data, expected byte, cycles, mode or flags
    word_t       tbl_word[$];     // Expected word or pulse setup
    word_t       rx_q[$];         // Words taken from the stream
    int          cycle_cnt;
    int          cycle_limit;
    logic [1:0]  ready_mode;      // 0 low, 1 high, 2 random
    logic [31:0] rnd_state;

    readout_top UUT (
        .CLK_40       (CLK_40),
        .i_arst_n     (i_arst_n),
        .i_bus_addr   (i_bus_addr),
        .i_bus_wdata  (i_bus_wdata),
        .i_bus_wr     (i_bus_wr),
        .i_bus_rd     (i_bus_rd),
        .i_trigger    (i_trigger),
        .i_data_ready (i_data_ready),
        .o_bus_rdata  (o_bus_rdata),
        .o_data_valid (o_data_valid),
        .o_data       (o_data),
        .o_busy       (o_busy),
        .o_gate       (o_gate),
        .o_inj_strb   (o_inj_strb)
    );

    always #10 CLK_40 = ~CLK_40;

    always @(posedge CLK_40)
    begin
        if (i_arst_n && o_data_valid && i_data_ready)
            rx_q.push_back(o_data);         // Transfer on this edge
    end

    always @(posedge CLK_40)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit)
        begin
            $display("Timeout: the test did not finish within %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $fatal(1, "Watchdog expired");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Id in the top nibble, count in the low half
    function automatic word_t make_word(input data_id_t id, input int cnt);
        return {id, 12'h000, count_t'(cnt)};
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "Check failed");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            stop_on_error($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_byte(input string name, input bus_data_t got, input bus_data_t exp);
        if (got !== exp)
            stop_on_error($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_on_error($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // All time steps of the stimulus go through here
    task automatic step_cycle();
        @(posedge CLK_40);
        #1;
        if (ready_mode == 2'd2)
        begin
            rnd_state    = xorshift32(rnd_state);
            i_data_ready = rnd_state[0];
        end
    endtask

    task automatic bus_write(input addr_t addr, input bus_data_t data);
        i_bus_addr  = addr;
        i_bus_wdata = data;
        i_bus_wr    = 1'b1;
        step_cycle();
        i_bus_wr    = 1'b0;
    endtask

    task automatic bus_read(input addr_t addr, input bus_data_t exp);
        i_bus_addr = addr;
        i_bus_rd   = 1'b1;
        step_cycle();
        i_bus_rd   = 1'b0;
        check_byte("o_bus_rdata", o_bus_rdata, exp);
    endtask

    task automatic trigger_pulse();
        i_trigger = 1'b1;
        repeat (2) step_cycle();
        i_trigger = 1'b0;
        repeat (2) step_cycle();
    endtask

    task automatic expect_word(input word_t exp);
        word_t got;
        while (rx_q.size() == 0)
            step_cycle();
        got = rx_q.pop_front();
        check_word("o_data", got, exp);
    endtask

    // Setup bytes low to high: gate delay, gate width, inj delay, inj width
    task automatic check_pulses(input word_t cfg);
        int gate_on;
        int gate_off;
        int inj_on;
        int inj_off;
        int span;
        gate_on  = int'(cfg[7:0]) + 1;
        gate_off = int'(cfg[7:0]) + int'(cfg[15:8]);
        inj_on   = gate_on + int'(cfg[23:16]) + 2;  // Starts on the edge after the gate rise
        inj_off  = inj_on + int'(cfg[31:24]) - 1;
        span     = ((gate_off > inj_off) ? gate_off : inj_off) + 3;
        bus_write(GATE_BASEADDR + REG_START, 8'h00);
        for (int k = 1; k <= span; k++)
        begin
            step_cycle();
            check_bit("o_gate", o_gate, (cfg[15:8] != 0) && k >= gate_on && k <= gate_off);
            check_bit("o_inj_strb", o_inj_strb,
                      (cfg[15:8] != 0) && (cfg[31:24] != 0) && k >= inj_on && k <= inj_off);
        end
    endtask

    // Flag bits: valid, busy, gate, injection strobe
    task automatic check_flags(input bus_data_t exp);
        check_bit("o_data_valid", o_data_valid, exp[0]);
        check_bit("o_busy", o_busy, exp[1]);
        check_bit("o_gate", o_gate, exp[2]);
        check_bit("o_inj_strb", o_inj_strb, exp[3]);
    endtask

    task automatic add_entry(input op_t op, input addr_t addr, input bus_data_t data,
                             input word_t word);
        tbl_op.push_back(op);
        tbl_addr.push_back(addr);
        tbl_data.push_back(data);
        tbl_word.push_back(word);
    endtask

    task automatic build_table();
        // Reset state
        add_entry(OP_FLAGS, '0, 8'h00, '0);
        add_entry(OP_READ, CFG_BASEADDR + REG_VERSION, VERSION, '0);
        add_entry(OP_READ, CFG_BASEADDR + REG_ENABLE, 8'h00, '0);
        add_entry(OP_READ, CFG_BASEADDR + REG_LOST, 8'h00, '0);
        // Trigger source on, then off
        add_entry(OP_WRITE, CFG_BASEADDR + REG_ENABLE, 8'h01, '0);
        add_entry(OP_READ, CFG_BASEADDR + REG_ENABLE, 8'h01, '0);
        for (int n = 0; n < 3; n++)
            add_entry(OP_TRIG, '0, 8'h00, '0);
        for (int n = 0; n < 3; n++)
            add_entry(OP_WORD, '0, 8'h00, make_word(TRG_DATA_ID, n));
        add_entry(OP_WRITE, CFG_BASEADDR + REG_ENABLE, 8'h00, '0);
        add_entry(OP_TRIG, '0, 8'h00, '0);
        add_entry(OP_TRIG, '0, 8'h00, '0);
        add_entry(OP_WAIT, '0, 8'd10, '0);
        add_entry(OP_IDLE, '0, 8'h00, '0);
        // Gate alone, delay 3 width 5
        add_entry(OP_WRITE, GATE_BASEADDR + REG_DELAY, 8'd3, '0);
        add_entry(OP_WRITE, GATE_BASEADDR + REG_WIDTH, 8'd5, '0);
        add_entry(OP_PULSE, '0, 8'h00, 32'h0000_0503);
        // Injection chained to the gate
        add_entry(OP_WRITE, INJ_BASEADDR + REG_DELAY, 8'd2, '0);
        add_entry(OP_WRITE, INJ_BASEADDR + REG_WIDTH, 8'd3, '0);
        add_entry(OP_WRITE, CFG_BASEADDR + REG_ENABLE, 8'h02, '0);
        add_entry(OP_PULSE, '0, 8'h00, 32'h0302_0503);
        add_entry(OP_WORD, '0, 8'h00, make_word(INJ_DATA_ID, 0));
        // Overflow under back-pressure, output register holds one more word
        add_entry(OP_WRITE, CFG_BASEADDR + REG_CLEAR, 8'h01, '0);
        add_entry(OP_WRITE, CFG_BASEADDR + REG_ENABLE, 8'h01, '0);
        add_entry(OP_READY, '0, 8'd0, '0);
        for (int n = 0; n < FIFO_DEPTH + 2; n++)
            add_entry(OP_TRIG, '0, 8'h00, '0);
        add_entry(OP_WAIT, '0, 8'd2, '0);
        add_entry(OP_FLAGS, '0, 8'h03, '0);
        add_entry(OP_READ, CFG_BASEADDR + REG_LOST, 8'h01, '0);
        add_entry(OP_READY, '0, 8'd1, '0);
        for (int n = 0; n <= FIFO_DEPTH; n++)
            add_entry(OP_WORD, '0, 8'h00, make_word(TRG_DATA_ID, n));
        add_entry(OP_FLAGS, '0, 8'h00, '0);
        add_entry(OP_TRIG, '0, 8'h00, '0);
        add_entry(OP_WORD, '0, 8'h00, make_word(TRG_DATA_ID, FIFO_DEPTH + 2));
        add_entry(OP_WRITE, CFG_BASEADDR + REG_CLEAR, 8'h01, '0);
        add_entry(OP_WRITE, CFG_BASEADDR + REG_LOST, 8'h00, '0);
        add_entry(OP_READ, CFG_BASEADDR + REG_LOST, 8'h00, '0);
        add_entry(OP_TRIG, '0, 8'h00, '0);
        add_entry(OP_WORD, '0, 8'h00, make_word(TRG_DATA_ID, 0));
        // Both sources filled, then drained with random ready
        add_entry(OP_WRITE, CFG_BASEADDR + REG_CLEAR, 8'h01, '0);
        add_entry(OP_READY, '0, 8'd0, '0);
        add_entry(OP_WRITE, CFG_BASEADDR + REG_ENABLE, 8'h03, '0);
        for (int n = 0; n < 3; n++)
            add_entry(OP_TRIG, '0, 8'h00, '0);
        for (int n = 0; n < 2; n++)
        begin
            add_entry(OP_WRITE, GATE_BASEADDR + REG_START, 8'h00, '0);
            add_entry(OP_WAIT, '0, 8'd20, '0);
        end
        add_entry(OP_READY, '0, 8'd2, '0);
        for (int n = 0; n < 2; n++)
        begin
            add_entry(OP_WORD, '0, 8'h00, make_word(TRG_DATA_ID, n));
            add_entry(OP_WORD, '0, 8'h00, make_word(INJ_DATA_ID, n));
        end
        add_entry(OP_WORD, '0, 8'h00, make_word(TRG_DATA_ID, 2));
        add_entry(OP_READY, '0, 8'd1, '0);
        add_entry(OP_WAIT, '0, 8'd10, '0);
        add_entry(OP_IDLE, '0, 8'h00, '0);
    endtask

    task automatic apply_entry(input op_t op, input addr_t addr, input bus_data_t data,
                               input word_t word);
        case (op)
            OP_WRITE: bus_write(addr, data);
            OP_READ:  bus_read(addr, data);
            OP_TRIG:  trigger_pulse();
            OP_WORD:  expect_word(word);
            OP_WAIT:  repeat (data) step_cycle();
            OP_PULSE: check_pulses(word);
            OP_FLAGS: check_flags(data);
            OP_READY:
            begin
                ready_mode = data[1:0];
                if (data != 8'd2)
                    i_data_ready = data[0];
            end
            OP_IDLE:
            begin
                if (rx_q.size() != 0)
                    stop_on_error($sformatf("Unexpected word 0x%h on the output stream", rx_q[0]));
            end
            default: stop_on_error("Unknown table entry");
        endcase
    endtask

    initial
    begin
        CLK_40       = 1'b0;
        i_arst_n     = 1'b0;
        i_bus_addr   = '0;
        i_bus_wdata  = '0;
        i_bus_wr     = 1'b0;
        i_bus_rd     = 1'b0;
        i_trigger    = 1'b0;
        i_data_ready = 1'b1;
        ready_mode   = 2'd1;
        rnd_state    = 32'h50953e16;
        cycle_cnt    = 0;
        build_table();
        cycle_limit  = tbl_op.size() * 50;
        repeat (2) @(posedge CLK_40);
        #1;
        i_arst_n = 1'b1;
        for (int n = 0; n < tbl_op.size(); n++)
            apply_entry(tbl_op[n], tbl_addr[n], tbl_data[n], tbl_word[n]);
        repeat (4) step_cycle();
        if (UUT.u_readout_props.assert_fail_cnt == 0)
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
        else
        begin
            $display("Concurrent assertions failed %0d times", UUT.u_readout_props.assert_fail_cnt);
            $display("Simulation finished: FAIL");
            $fatal(1, "Assertion failures");
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
logic/readout_pkg.sv
logic/pulse_gen.sv
logic/event_fifo.sv
logic/rr_arbiter.sv
logic/config_regs.sv
logic/readout_top.sv
dv/readout_properties.sv
dv/readout_tb.sv

// File: Bender.yml
package:
  name: readout_core

sources:
  - files:
      - logic/readout_pkg.sv
      - logic/pulse_gen.sv
      - logic/event_fifo.sv
      - logic/rr_arbiter.sv
      - logic/config_regs.sv
      - logic/readout_top.sv
  - target: test
    files:
      - dv/readout_properties.sv
      - dv/readout_tb.sv
